// ==== files.f ====
+incdir+source
source/regmap_pkg.sv
source/motor_pkg.sv
source/host_decoder.sv
source/drive_channel.sv
source/rotation_channel.sv
source/read_mux.sv
source/motor_regs_top.sv
verification/motor_regs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the motor register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module motor_regs_tb -Mdir obj_dir

out=$(./obj_dir/Vmotor_regs_tb)
echo "$out"

# Pass only if the testbench printed the pass line
echo "$out" | grep -qx "TEST PASS"

// ==== source/drive_channel.sv ====
// One drive motor, control byte with readback and a sampled status byte
// Status lags the motor inputs by one cycle

`default_nettype none

`include "motor_cfg.svh"

module drive_channel (
    input wire clock,
    input wire rst_n,
    input wire ctrl_we, // Own address or broadcast
    input wire [`DATA_W-1:0] wr_data,
    input wire motor_pkg::drive_status_t status_in,
    output motor_pkg::drive_ctrl_t ctrl,
    output logic [`DATA_W-1:0] ctrl_byte,
    output logic [`DATA_W-1:0] status_byte
);

    import motor_pkg::*;

    // Control register, byte layout equals the struct
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0; // Motor off, brake released
        end else if (ctrl_we) begin
            ctrl <= drive_ctrl_t'(wr_data);
        end
    end

    assign ctrl_byte = ctrl; // Readback of what drives the motor

    // Free running status sample
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            status_byte <= '0;
        end else begin
            status_byte <= status_in; // Fault, startup fail, temperature
        end
    end

endmodule

`default_nettype wire

// ==== source/host_decoder.sv ====
// Combinational host address decode into region, channel and offset
// Broadcasts hit every drive control byte and nothing else
// Drive status and rotation snapshot offsets raise no strobe

`default_nettype none

`include "motor_cfg.svh"

module host_decoder (
    input wire [`ADDR_W-1:0] address,
    input wire write_en,
    output regmap_pkg::dec_addr_t dec,
    output regmap_pkg::wr_strobe_t strobes
);

    import regmap_pkg::*;

    // Region bounds, end is exclusive
    localparam addr_t DRV_BASE = addr_t'(`ADDR_DRIVE_BASE);
    localparam addr_t DRV_END = addr_t'(`ADDR_DRIVE_BASE + `NUM_DRIVE * `DRIVE_STRIDE);
    localparam addr_t ROT_BASE = addr_t'(`ADDR_ROT_BASE);
    localparam addr_t ROT_END = addr_t'(`ADDR_ROT_BASE + `NUM_ROT * `ROT_STRIDE);
    localparam addr_t DRV_STR = addr_t'(`DRIVE_STRIDE);
    localparam addr_t ROT_STR = addr_t'(`ROT_STRIDE);
    localparam addr_t BCAST_ALL = addr_t'(`ADDR_BCAST_ALL);
    localparam addr_t BCAST_DRV = addr_t'(`ADDR_BCAST_DRIVE);

    addr_t drv_rel, drv_idx, drv_ofs;
    addr_t rot_rel, rot_idx, rot_ofs;
    ofs_t rot_ofs_s;

    // Split into channel and offset, constant divisors
    assign drv_rel = address - DRV_BASE;
    assign drv_idx = drv_rel / DRV_STR;
    assign drv_ofs = drv_rel % DRV_STR;
    assign rot_rel = address - ROT_BASE;
    assign rot_idx = rot_rel / ROT_STR;
    assign rot_ofs = rot_rel % ROT_STR;
    assign rot_ofs_s = rot_ofs[OFS_W-1:0];

    always_comb begin
        dec = '0; // REG_NONE
        strobes = '0;
        if (address == BCAST_ALL || address == BCAST_DRV) begin
            dec.region = REG_BCAST;
            strobes.drive_ctrl = {`NUM_DRIVE{write_en}};
        end else if (address >= DRV_BASE && address < DRV_END) begin
            dec.region = REG_DRIVE;
            dec.index = drv_idx[IDX_W-1:0];
            dec.offset = drv_ofs[OFS_W-1:0];
            if (dec.offset == DRV_OFS_CTRL) begin
                strobes.drive_ctrl[dec.index] = write_en;
            end
        end else if (address >= ROT_BASE && address < ROT_END) begin
            dec.region = REG_ROT;
            dec.index = rot_idx[IDX_W-1:0];
            dec.offset = rot_ofs_s;
            // Only control, target and command slots are writable
            if (rot_ofs_s != OFS_ANGLE_LO && rot_ofs_s <= OFS_ANGLE_CMD) begin
                strobes.rot[dec.index][rot_ofs_s[1:0]] = write_en;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/motor_cfg.svh ====
// Channel counts, field widths and host address map of the motor register block
// Drive and rotation index widths follow the larger channel count
// Rotation offsets 4 to 6 have no register and read as zero

`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

// Channel counts
`define NUM_DRIVE 4
`define NUM_ROT 4

// Host bus
`define ADDR_W 6
`define DATA_W 8

// Motor side field widths
`define ANGLE_W 12 // Upper bits beyond DATA_W live in the rotation control byte
`define TEMP_W 6
`define PWM_W 5

// Broadcast addresses, both reach every drive control byte
`define ADDR_BCAST_ALL 'h01
`define ADDR_BCAST_DRIVE 'h03

// Drive block, control then status per channel
`define ADDR_DRIVE_BASE 'h04
`define DRIVE_STRIDE 2

// Rotation block
`define ADDR_ROT_BASE 'h0C
`define ROT_STRIDE 7

// Register offsets inside one rotation channel
`define ROT_OFS_CTRL 0
`define ROT_OFS_TARGET 1
`define ROT_OFS_ANGLE_LO 2 // Read only snapshot low byte
`define ROT_OFS_ANGLE_CMD 3 // Command on write, status on read

`endif

// ==== source/motor_pkg.sv ====
// Motor side bundles, field order matches the host byte layouts
// Rotation bundles carry the full angle width from the config header

`default_nettype none

`include "motor_cfg.svh"

package motor_pkg;

    // Drive control byte, MSB first
    typedef struct packed {
        logic brake; // Bit 7
        logic sd_enable; // Bit 6, driver shutdown release
        logic direction; // Bit 5
        logic [`PWM_W-1:0] pwm; // Duty ratio
    } drive_ctrl_t;

    // Drive status byte as seen by the host
    typedef struct packed {
        logic fault; // Driver fault flag
        logic startup_fail; // Power on self check failed
        logic [`TEMP_W-1:0] adc_temp; // Raw ADC temperature
    } drive_status_t;

    // Outputs toward one swerve rotation controller
    typedef struct packed {
        logic i2c_calib_en; // Encoder calibration over I2C
        logic sr_enable;
        logic enable_stall_chk;
        logic [`ANGLE_W-1:0] target_angle;
        logic update_angle; // One cycle pulse
        logic abort_angle; // One cycle pulse
    } rot_ctrl_t;

    // Feedback from one rotation controller
    typedef struct packed {
        logic [`ANGLE_W-1:0] current_angle; // Live encoder angle
        logic angle_done; // Target reached
    } rot_fb_t;

endpackage

`default_nettype wire

// ==== source/motor_regs_top.sv ====
// Host register block for four drive and four swerve rotation motors
// Plain write and read strobes, no handshake and no stall
// One rotation startup fail input is shared by all rotation channels

`default_nettype none

`include "motor_cfg.svh"

module motor_regs_top (
    input wire clock,
    input wire rst_n,
    input wire [`ADDR_W-1:0] address,
    input wire write_en,
    input wire [`DATA_W-1:0] wr_data,
    input wire read_en,
    input wire motor_pkg::drive_status_t [`NUM_DRIVE-1:0] drive_status,
    input wire motor_pkg::rot_fb_t [`NUM_ROT-1:0] rot_fb,
    input wire rot_startup_fail,
    output wire [`DATA_W-1:0] rd_data,
    output wire motor_pkg::drive_ctrl_t [`NUM_DRIVE-1:0] drive_ctrl,
    output wire motor_pkg::rot_ctrl_t [`NUM_ROT-1:0] rot_ctrl
);

    import regmap_pkg::*;

    wire dec_addr_t dec;
    wire wr_strobe_t strobes;
    wire [`NUM_DRIVE-1:0][`DATA_W-1:0] drive_ctrl_bytes;
    wire [`NUM_DRIVE-1:0][`DATA_W-1:0] drive_status_bytes;
    wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_ctrl_bytes;
    wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_target_bytes;
    wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_angle_lo_bytes;
    wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_angle_status_bytes;

    host_decoder u_decoder (
        .address (address),
        .write_en(write_en),
        .dec     (dec),
        .strobes (strobes)
    );

    for (genvar i = 0; i < `NUM_DRIVE; i++) begin : g_drive
        drive_channel u_drive (
            .clock      (clock),
            .rst_n      (rst_n),
            .ctrl_we    (strobes.drive_ctrl[i]),
            .wr_data    (wr_data),
            .status_in  (drive_status[i]),
            .ctrl       (drive_ctrl[i]),
            .ctrl_byte  (drive_ctrl_bytes[i]),
            .status_byte(drive_status_bytes[i])
        );
    end

    // Strobe slots picked by register offset
    for (genvar i = 0; i < `NUM_ROT; i++) begin : g_rot
        rotation_channel u_rot (
            .clock            (clock),
            .rst_n            (rst_n),
            .ctrl_we          (strobes.rot[i][OFS_CTRL[1:0]]),
            .target_we        (strobes.rot[i][OFS_TARGET[1:0]]),
            .cmd_we           (strobes.rot[i][OFS_ANGLE_CMD[1:0]]),
            .wr_data          (wr_data),
            .startup_fail     (rot_startup_fail),
            .fb               (rot_fb[i]),
            .ctrl             (rot_ctrl[i]),
            .ctrl_byte        (rot_ctrl_bytes[i]),
            .target_byte      (rot_target_bytes[i]),
            .angle_lo_byte    (rot_angle_lo_bytes[i]),
            .angle_status_byte(rot_angle_status_bytes[i])
        );
    end

    read_mux u_read_mux (
        .clock                 (clock),
        .rst_n                 (rst_n),
        .read_en               (read_en),
        .dec                   (dec),
        .drive_ctrl_bytes      (drive_ctrl_bytes),
        .drive_status_bytes    (drive_status_bytes),
        .rot_ctrl_bytes        (rot_ctrl_bytes),
        .rot_target_bytes      (rot_target_bytes),
        .rot_angle_lo_bytes    (rot_angle_lo_bytes),
        .rot_angle_status_bytes(rot_angle_status_bytes),
        .rd_data               (rd_data)
    );

endmodule

`default_nettype wire

// ==== source/read_mux.sv ====
// Registered read path, one cycle latency, data holds until next read
// Unmapped, broadcast and reserved addresses return zero

`default_nettype none

`include "motor_cfg.svh"

module read_mux (
    input wire clock,
    input wire rst_n,
    input wire read_en,
    input wire regmap_pkg::dec_addr_t dec,
    input wire [`NUM_DRIVE-1:0][`DATA_W-1:0] drive_ctrl_bytes,
    input wire [`NUM_DRIVE-1:0][`DATA_W-1:0] drive_status_bytes,
    input wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_ctrl_bytes,
    input wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_target_bytes,
    input wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_angle_lo_bytes,
    input wire [`NUM_ROT-1:0][`DATA_W-1:0] rot_angle_status_bytes,
    output logic [`DATA_W-1:0] rd_data
);

    import regmap_pkg::*;

    logic [`DATA_W-1:0] sel_byte;

    always_comb begin
        sel_byte = '0; // Default for anything unmapped
        case (dec.region)
            REG_DRIVE: begin
                if (dec.offset == DRV_OFS_STATUS) begin
                    sel_byte = drive_status_bytes[dec.index];
                end else begin
                    sel_byte = drive_ctrl_bytes[dec.index];
                end
            end
            REG_ROT: begin
                case (dec.offset)
                    OFS_CTRL: sel_byte = rot_ctrl_bytes[dec.index];
                    OFS_TARGET: sel_byte = rot_target_bytes[dec.index];
                    OFS_ANGLE_LO: sel_byte = rot_angle_lo_bytes[dec.index];
                    OFS_ANGLE_CMD: sel_byte = rot_angle_status_bytes[dec.index];
                    default: sel_byte = '0; // Dropped gain and override slots
                endcase
            end
            default: sel_byte = '0; // Broadcast and none
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= sel_byte;
        end
    end

endmodule

`default_nettype wire

// ==== source/regmap_pkg.sv ====
// Host side register map types for the motor register block
// Offsets are 3 bits wide, so a stride above 8 needs OFS_W raised

`default_nettype none

`include "motor_cfg.svh"

package regmap_pkg;

    localparam int MAX_CH = (`NUM_DRIVE > `NUM_ROT) ? `NUM_DRIVE : `NUM_ROT;
    localparam int IDX_W = $clog2(MAX_CH); // Channel index inside a region
    localparam int OFS_W = 3; // Register offset inside a channel
    localparam int ROT_REGS = 4; // Writable slots per rotation channel, by offset

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [OFS_W-1:0] ofs_t;

    // Offsets as typed constants
    localparam ofs_t DRV_OFS_CTRL = ofs_t'(0);
    localparam ofs_t DRV_OFS_STATUS = ofs_t'(1);
    localparam ofs_t OFS_CTRL = ofs_t'(`ROT_OFS_CTRL);
    localparam ofs_t OFS_TARGET = ofs_t'(`ROT_OFS_TARGET);
    localparam ofs_t OFS_ANGLE_LO = ofs_t'(`ROT_OFS_ANGLE_LO);
    localparam ofs_t OFS_ANGLE_CMD = ofs_t'(`ROT_OFS_ANGLE_CMD);

    typedef enum logic [1:0] {
        REG_NONE, // Reserved, dropped or out of range
        REG_DRIVE,
        REG_ROT,
        REG_BCAST
    } region_e;

    typedef struct packed {
        region_e region;
        idx_t index;
        ofs_t offset;
    } dec_addr_t;

    // Rotation strobes indexed by offset, the snapshot slot never fires
    typedef struct packed {
        logic [`NUM_DRIVE-1:0] drive_ctrl;
        logic [`NUM_ROT-1:0][ROT_REGS-1:0] rot;
    } wr_strobe_t;

    // Write view of the angle word
    typedef struct packed {
        logic unused_hi;
        logic snapshot; // Capture current angle
        logic update; // Start move to target
        logic abort; // Stop the move
        logic [3:0] unused_lo;
    } rot_cmd_t;

    // Read view of the same byte
    typedef struct packed {
        logic angle_done;
        logic [2:0] zero;
        logic [`ANGLE_W-`DATA_W-1:0] angle_hi; // Snapshot upper bits
    } rot_status_t;

    typedef union packed {
        rot_cmd_t cmd;
        rot_status_t status;
    } angle_word_u;

endpackage

`default_nettype wire

// ==== source/rotation_channel.sv ====
// One swerve rotation motor, control, target, angle snapshot and pulses
// Startup fail is taken into control bit 4 only when control is written
// Snapshot readback bytes lag the capture by one cycle

`default_nettype none

`include "motor_cfg.svh"

module rotation_channel (
    input wire clock,
    input wire rst_n,
    input wire ctrl_we,
    input wire target_we,
    input wire cmd_we, // Angle command byte written
    input wire [`DATA_W-1:0] wr_data,
    input wire startup_fail,
    input wire motor_pkg::rot_fb_t fb,
    output motor_pkg::rot_ctrl_t ctrl,
    output logic [`DATA_W-1:0] ctrl_byte,
    output logic [`DATA_W-1:0] target_byte,
    output logic [`DATA_W-1:0] angle_lo_byte,
    output logic [`DATA_W-1:0] angle_status_byte
);

    import regmap_pkg::*;

    logic [`DATA_W-1:0] ctrl_q; // calib, enable, stall chk, startup fail, target hi
    logic [`DATA_W-1:0] target_q; // Target low byte
    logic [`ANGLE_W-1:0] snap_q;
    logic update_q;
    logic abort_q;
    angle_word_u cmd_word;
    angle_word_u status_word;

    assign cmd_word = wr_data; // Command view of the written byte

    // Host writable registers
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            target_q <= '0;
        end else begin
            if (ctrl_we) begin
                ctrl_q <= {wr_data[7:5], startup_fail, wr_data[3:0]};
            end
            if (target_we) begin
                target_q <= wr_data;
            end
        end
    end

    // Pulses last the single cycle after the command write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_q <= 1'b0;
            abort_q <= 1'b0;
            snap_q <= '0;
        end else begin
            update_q <= cmd_we & cmd_word.cmd.update;
            abort_q <= cmd_we & cmd_word.cmd.abort;
            // Freeze angle so both bytes read back from one sample
            if (cmd_we && cmd_word.cmd.snapshot) begin
                snap_q <= fb.current_angle;
            end
        end
    end

    // Status view, done flag live and zero filler
    always_comb begin
        status_word = '0;
        status_word.status.angle_done = fb.angle_done;
        status_word.status.angle_hi = snap_q[`ANGLE_W-1:`DATA_W];
    end

    // Readback bytes re-sampled every cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            angle_lo_byte <= '0;
            angle_status_byte <= '0;
        end else begin
            angle_lo_byte <= snap_q[`DATA_W-1:0];
            angle_status_byte <= status_word;
        end
    end

    // Motor side outputs
    assign ctrl.i2c_calib_en = ctrl_q[7];
    assign ctrl.sr_enable = ctrl_q[6];
    assign ctrl.enable_stall_chk = ctrl_q[5];
    assign ctrl.target_angle = {ctrl_q[`ANGLE_W-`DATA_W-1:0], target_q};
    assign ctrl.update_angle = update_q;
    assign ctrl.abort_angle = abort_q;

    assign ctrl_byte = ctrl_q; // Bit 4 shows startup fail at write time
    assign target_byte = target_q;

endmodule

`default_nettype wire

// ==== verification/motor_regs_tb.sv ====
// Self-checking testbench for the motor register block
// Concurrent assertions sample on the falling clock edge and compare against a reference model
// The model follows the host address map and the one-cycle register timing

`default_nettype none

`include "motor_cfg.svh"

module motor_regs_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import motor_pkg::*;

    typedef logic [`ADDR_W-1:0] addr_t;

    localparam int HALF_PERIOD = 20; // 40 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int PULSE_WAIT = 8; // Cycles allowed for a pulse to show
    localparam int WATCHDOG_CYCLES = 5000;

    logic clock;
    logic rst_n;
    addr_t address;
    logic write_en;
    logic [`DATA_W-1:0] wr_data;
    logic read_en;
    drive_status_t [`NUM_DRIVE-1:0] drive_status;
    rot_fb_t [`NUM_ROT-1:0] rot_fb;
    logic rot_startup_fail;
    wire [`DATA_W-1:0] rd_data;
    wire drive_ctrl_t [`NUM_DRIVE-1:0] drive_ctrl;
    wire rot_ctrl_t [`NUM_ROT-1:0] rot_ctrl;

    // Reference model state
    logic [`DATA_W-1:0] exp_drive [`NUM_DRIVE];
    logic [`DATA_W-1:0] exp_status [`NUM_DRIVE]; // One cycle behind the motor
    logic [`DATA_W-1:0] exp_rot_ctrl [`NUM_ROT];
    logic [`DATA_W-1:0] exp_target [`NUM_ROT];
    logic [`ANGLE_W-1:0] exp_snap [`NUM_ROT];
    logic [`DATA_W-1:0] exp_angle_lo [`NUM_ROT];
    logic [`DATA_W-1:0] exp_angle_st [`NUM_ROT];
    logic exp_update [`NUM_ROT];
    logic exp_abort [`NUM_ROT];
    logic [`DATA_W-1:0] exp_rd;

    integer seed = 3882;
    int err_count = 0; // Assertion failures
    int timeout_count = 0;
    int tests_run = 0;

    motor_regs_top u_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .address         (address),
        .write_en        (write_en),
        .wr_data         (wr_data),
        .read_en         (read_en),
        .drive_status    (drive_status),
        .rot_fb          (rot_fb),
        .rot_startup_fail(rot_startup_fail),
        .rd_data         (rd_data),
        .drive_ctrl      (drive_ctrl),
        .rot_ctrl        (rot_ctrl)
    );

    always #HALF_PERIOD clock = ~clock;

    function automatic addr_t drive_addr(input int ch, input int ofs);
        return addr_t'(`ADDR_DRIVE_BASE + ch * `DRIVE_STRIDE + ofs); // ofs 1 is status
    endfunction

    function automatic addr_t rot_addr(input int ch, input int ofs);
        return addr_t'(`ADDR_ROT_BASE + ch * `ROT_STRIDE + ofs);
    endfunction

    function automatic logic [`DATA_W-1:0] rand_byte();
        return 8'($random(seed));
    endfunction

    // Expected read byte for an address from model state
    function automatic logic [`DATA_W-1:0] read_value(input addr_t a);
        int rel;
        int ch;
        int ofs;
        read_value = '0; // Unmapped, reserved, broadcast
        rel = int'(a) - `ADDR_DRIVE_BASE;
        if (rel >= 0 && rel < `NUM_DRIVE * `DRIVE_STRIDE) begin
            ch = rel / `DRIVE_STRIDE;
            read_value = (rel % `DRIVE_STRIDE == 0) ? exp_drive[ch] : exp_status[ch];
        end
        rel = int'(a) - `ADDR_ROT_BASE;
        if (rel >= 0 && rel < `NUM_ROT * `ROT_STRIDE) begin
            ch = rel / `ROT_STRIDE;
            ofs = rel % `ROT_STRIDE;
            case (ofs)
                `ROT_OFS_CTRL: read_value = exp_rot_ctrl[ch];
                `ROT_OFS_TARGET: read_value = exp_target[ch];
                `ROT_OFS_ANGLE_LO: read_value = exp_angle_lo[ch];
                `ROT_OFS_ANGLE_CMD: read_value = exp_angle_st[ch];
                default: read_value = '0; // Dropped gain and override slots
            endcase
        end
    endfunction

    // Model registers update on the same edge as the DUT
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_DRIVE; i++) begin
                exp_drive[i] <= '0;
                exp_status[i] <= '0;
            end
            for (int i = 0; i < `NUM_ROT; i++) begin
                exp_rot_ctrl[i] <= '0;
                exp_target[i] <= '0;
                exp_snap[i] <= '0;
                exp_angle_lo[i] <= '0;
                exp_angle_st[i] <= '0;
                exp_update[i] <= 1'b0;
                exp_abort[i] <= 1'b0;
            end
            exp_rd <= '0;
        end else begin
            for (int i = 0; i < `NUM_DRIVE; i++) begin
                exp_status[i] <= drive_status[i];
                if (write_en && (address == drive_addr(i, 0)
                        || address == addr_t'(`ADDR_BCAST_ALL)
                        || address == addr_t'(`ADDR_BCAST_DRIVE))) begin
                    exp_drive[i] <= wr_data;
                end
            end
            for (int i = 0; i < `NUM_ROT; i++) begin
                exp_update[i] <= write_en && address == rot_addr(i, `ROT_OFS_ANGLE_CMD)
                        && wr_data[5];
                exp_abort[i] <= write_en && address == rot_addr(i, `ROT_OFS_ANGLE_CMD)
                        && wr_data[4];
                if (write_en && address == rot_addr(i, `ROT_OFS_ANGLE_CMD) && wr_data[6]) begin
                    exp_snap[i] <= rot_fb[i].current_angle;
                end
                if (write_en && address == rot_addr(i, `ROT_OFS_CTRL)) begin
                    exp_rot_ctrl[i] <= {wr_data[7:5], rot_startup_fail, wr_data[3:0]};
                end
                if (write_en && address == rot_addr(i, `ROT_OFS_TARGET)) begin
                    exp_target[i] <= wr_data;
                end
                exp_angle_lo[i] <= exp_snap[i][7:0];
                // Done is live
                exp_angle_st[i] <= {rot_fb[i].angle_done, 3'b000, exp_snap[i][11:8]};
            end
            if (read_en) begin
                exp_rd <= read_value(address);
            end
        end
    end

    // During reset and the first cycle after it
    assert property (@(negedge clock) (!rst_n || !$past(rst_n))
            |-> (drive_ctrl == '0 && rot_ctrl == '0 && rd_data == '0))
    else begin
        $display("** Error at %0t ns: reset expected 0 got drive_ctrl %h rot_ctrl %h rd_data %h",
                 $time, drive_ctrl, rot_ctrl, rd_data);
        err_count++;
    end

    assert property (@(negedge clock) disable iff (!rst_n) rd_data == exp_rd)
    else begin
        $display("** Error at %0t ns: rd_data expected %h got %h", $time, exp_rd, rd_data);
        err_count++;
    end

    for (genvar i = 0; i < `NUM_DRIVE; i++) begin : g_drive_chk
        assert property (@(negedge clock) disable iff (!rst_n) drive_ctrl[i] == exp_drive[i])
        else begin
            $display("** Error at %0t ns: drive_ctrl[%0d] expected %h got %h",
                     $time, i, exp_drive[i], drive_ctrl[i]);
            err_count++;
        end
    end

    for (genvar i = 0; i < `NUM_ROT; i++) begin : g_rot_chk
        assert property (@(negedge clock) disable iff (!rst_n)
                rot_ctrl[i].target_angle == {exp_rot_ctrl[i][3:0], exp_target[i]})
        else begin
            $display("** Error at %0t ns: rot_ctrl[%0d].target_angle expected %h got %h",
                     $time, i, {exp_rot_ctrl[i][3:0], exp_target[i]}, rot_ctrl[i].target_angle);
            err_count++;
        end
        assert property (@(negedge clock) disable iff (!rst_n)
                {rot_ctrl[i].i2c_calib_en, rot_ctrl[i].sr_enable, rot_ctrl[i].enable_stall_chk}
                == exp_rot_ctrl[i][7:5])
        else begin
            $display("** Error at %0t ns: rot_ctrl[%0d] enables expected %b got %b",
                     $time, i, exp_rot_ctrl[i][7:5],
                     {rot_ctrl[i].i2c_calib_en, rot_ctrl[i].sr_enable,
                     rot_ctrl[i].enable_stall_chk});
            err_count++;
        end
        assert property (@(negedge clock) disable iff (!rst_n)
                rot_ctrl[i].update_angle == exp_update[i]
                && rot_ctrl[i].abort_angle == exp_abort[i])
        else begin
            $display("** Error at %0t ns: rot_ctrl[%0d] update/abort expected %b%b got %b%b",
                     $time, i, exp_update[i], exp_abort[i],
                     rot_ctrl[i].update_angle, rot_ctrl[i].abort_angle);
            err_count++;
        end
    end

    task automatic write_reg(input addr_t a, input logic [`DATA_W-1:0] d);
        @(posedge clock);
        address <= a;
        wr_data <= d;
        write_en <= 1'b1;
        @(posedge clock); // DUT takes the write here
        write_en <= 1'b0;
    endtask

    task automatic read_reg(input addr_t a);
        @(posedge clock);
        address <= a;
        read_en <= 1'b1;
        @(posedge clock);
        read_en <= 1'b0;
    endtask

    task automatic apply_reset();
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clock);
        end
        rst_n <= 1'b1;
    endtask

    // Bounded loop until the pulse shows
    task automatic wait_for_pulse(input int ch, input bit abort_sel);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < PULSE_WAIT && !seen; n++) begin
            @(negedge clock);
            seen = abort_sel ? rot_ctrl[ch].abort_angle : rot_ctrl[ch].update_angle;
        end
        if (!seen) begin
            $display("Timed out at %0t ns waiting for a %s pulse on rotation channel %0d",
                     $time, abort_sel ? "abort" : "update", ch);
            timeout_count++;
        end
    endtask

    task automatic end_test(input string name, input int fails_before);
        for (int n = 0; n < 3; n++) begin
            @(posedge clock); // Let the last checks run
        end
        tests_run++;
        if (err_count + timeout_count == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, err_count + timeout_count - fails_before);
        end
    endtask

    task automatic drive_tests();
        for (int i = 0; i < `NUM_DRIVE; i++) begin
            write_reg(drive_addr(i, 0), rand_byte()); // Others must hold
            read_reg(drive_addr(i, 0));
        end
        write_reg(addr_t'(`ADDR_BCAST_ALL), rand_byte());
        read_reg(drive_addr(2, 0));
        write_reg(addr_t'(`ADDR_BCAST_DRIVE), rand_byte());
        read_reg(drive_addr(1, 0));
        read_reg(addr_t'(`ADDR_BCAST_DRIVE)); // Broadcast reads zero
    endtask

    task automatic status_tests();
        for (int i = 0; i < `NUM_DRIVE; i++) begin
            drive_status[i] <= rand_byte();
        end
        @(posedge clock);
        for (int i = 0; i < `NUM_DRIVE; i++) begin
            read_reg(drive_addr(i, 1));
        end
        read_reg(addr_t'('h00));
        read_reg(addr_t'('h02)); // Reserved slot
        for (int ch = 0; ch < `NUM_ROT; ch++) begin
            for (int ofs = 4; ofs < `ROT_STRIDE; ofs++) begin
                read_reg(rot_addr(ch, ofs));
            end
        end
        for (int a = 'h2A; a < (1 << `ADDR_W); a++) begin
            read_reg(addr_t'(a));
        end
    endtask

    task automatic target_tests();
        logic [`DATA_W-1:0] r;
        for (int ch = 0; ch < `NUM_ROT; ch++) begin
            r = rand_byte();
            rot_startup_fail <= r[0];
            write_reg(rot_addr(ch, `ROT_OFS_CTRL), rand_byte());
            write_reg(rot_addr(ch, `ROT_OFS_TARGET), rand_byte());
            rot_startup_fail <= ~r[0]; // Readback keeps the old value
            read_reg(rot_addr(ch, `ROT_OFS_CTRL));
            read_reg(rot_addr(ch, `ROT_OFS_TARGET));
        end
    endtask

    task automatic pulse_tests();
        for (int ch = 0; ch < `NUM_ROT; ch++) begin
            write_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD), 8'h20);
            wait_for_pulse(ch, 1'b0);
            write_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD), 8'h10);
            wait_for_pulse(ch, 1'b1);
            write_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD), 8'h8F); // Unused bits only
        end
    endtask

    task automatic snapshot_tests();
        logic [`ANGLE_W-1:0] angle;
        for (int ch = 0; ch < `NUM_ROT; ch++) begin
            angle = 12'($random(seed)) | 12'h101; // Both bytes nonzero
            rot_fb[ch].current_angle <= angle;
            rot_fb[ch].angle_done <= 1'b0;
            write_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD), 8'h40);
            rot_fb[ch].current_angle <= ~angle; // Every bit moves after capture
            read_reg(rot_addr(ch, `ROT_OFS_ANGLE_LO));
            read_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD));
            rot_fb[ch].angle_done <= 1'b1;
            read_reg(rot_addr(ch, `ROT_OFS_ANGLE_CMD));
        end
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        address = '0;
        write_en = 1'b0;
        wr_data = '0;
        read_en = 1'b0;
        drive_status = '0;
        rot_fb = '0;
        rot_startup_fail = 1'b0;
        apply_reset();
        end_test("reset", 0);
        drive_tests();
        end_test("drive writes and broadcast", err_count + timeout_count);
        status_tests();
        end_test("drive status and unmapped reads", err_count + timeout_count);
        target_tests();
        end_test("rotation target", err_count + timeout_count);
        pulse_tests();
        end_test("update and abort pulses", err_count + timeout_count);
        snapshot_tests();
        end_test("angle snapshot", err_count + timeout_count);
        $display("%0d tests, %0d assertion errors, %0d timeouts",
                 tests_run, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Whole run bound
    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("Simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
